// ==== source/mem_decoder_pkg.sv ====
`default_nettype none

package mem_decoder_pkg;

   //////////////////////////////
   // widths
   //////////////////////////////

   // request address and data word
   localparam int addr_w = 32;
   localparam int data_w = 32;
   // one strobe per byte lane
   localparam int strb_w = data_w / 8;
   // address bits below the word index
   localparam int byte_offset_w = 2;

   //////////////////////////////
   // region decode
   //////////////////////////////

   // 0x8000_0000 and up go to the kernel bank
   localparam int kernel_region_bit = 31;
   // 0x1_0000 window goes to the argument bank
   localparam int arg_region_bit = 16;

   // single-beat request, write or read
   typedef struct packed {
      logic                write;
      logic [addr_w-1:0]   addr;
      logic [data_w-1:0]   wdata;
      logic [strb_w-1:0]   strb;
   } mem_req_t;

   // old word content, also for writes
   typedef struct packed {
      logic [data_w-1:0]   rdata;
   } mem_rsp_t;

   typedef enum logic {
      bank_kernel,
      bank_arg
   } bank_sel_t;

endpackage

`default_nettype wire

// ==== source/ram_bank.sv ====
`default_nettype none

module ram_bank #(
   parameter int bank_words = 256
) (
   input  logic                                 clk,
   input  logic                                 en,
   input  logic                                 we,
   input  logic [$clog2(bank_words)-1:0]        offset,
   input  logic [mem_decoder_pkg::data_w-1:0]   wdata,
   input  logic [mem_decoder_pkg::strb_w-1:0]   strb,
   output logic [mem_decoder_pkg::data_w-1:0]   rdata
);

   // word storage, contents undefined after reset
   logic [mem_decoder_pkg::data_w-1:0] mem [bank_words];

   //////////////////////////////
   // single port access
   //////////////////////////////

   // read-first, rdata gets the word before the write
   always_ff @(posedge clk) begin
      if (en) begin
         rdata <= mem[offset];
      end
   end

   // byte lanes written under their strobe
   always_ff @(posedge clk) begin
      if (en && we) begin
         for (int lane = 0; lane < mem_decoder_pkg::strb_w; lane++) begin
            if (strb[lane]) begin
               mem[offset][8*lane +: 8] <= wdata[8*lane +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== source/bank_select.sv ====
`default_nettype none

module bank_select #(
   parameter int kernel_words = 256,
   parameter int arg_words    = 64
) (
   input  logic                                    clk,
   input  logic                                    reset,
   input  logic                                    access_en,
   input  mem_decoder_pkg::mem_req_t               held_req,
   output logic [mem_decoder_pkg::data_w-1:0]      rd_data,
   output logic                                    kernel_en,
   output logic                                    arg_en,
   output logic                                    bank_we,
   output logic [$clog2(kernel_words)-1:0]         kernel_offset,
   output logic [$clog2(arg_words)-1:0]            arg_offset,
   output logic [mem_decoder_pkg::data_w-1:0]      bank_wdata,
   output logic [mem_decoder_pkg::strb_w-1:0]      bank_strb,
   input  logic [mem_decoder_pkg::data_w-1:0]      kernel_rdata,
   input  logic [mem_decoder_pkg::data_w-1:0]      arg_rdata
);

   localparam int kernel_off_w = $clog2(kernel_words);
   localparam int arg_off_w    = $clog2(arg_words);

   mem_decoder_pkg::bank_sel_t sel;
   mem_decoder_pkg::bank_sel_t sel_q;

   //////////////////////////////
   // region decode
   //////////////////////////////

   // arg bank only for bit 16 with bit 31 clear
   // everything else lands in the kernel bank
   assign sel = (!held_req.addr[mem_decoder_pkg::kernel_region_bit] &&
                 held_req.addr[mem_decoder_pkg::arg_region_bit]) ?
                mem_decoder_pkg::bank_arg : mem_decoder_pkg::bank_kernel;

   // strobe reaches the chosen bank only
   assign kernel_en = access_en && (sel == mem_decoder_pkg::bank_kernel);
   assign arg_en    = access_en && (sel == mem_decoder_pkg::bank_arg);

   // word index, upper bits dropped so the bank wraps
   assign kernel_offset = held_req.addr[mem_decoder_pkg::byte_offset_w +: kernel_off_w];
   assign arg_offset    = held_req.addr[mem_decoder_pkg::byte_offset_w +: arg_off_w];

   // shared by both banks, enables keep them apart
   assign bank_we    = held_req.write;
   assign bank_wdata = held_req.wdata;
   assign bank_strb  = held_req.strb;

   //////////////////////////////
   // read return
   //////////////////////////////

   // remember the bank used on the access edge
   always_ff @(posedge clk) begin
      if (reset) begin
         sel_q <= mem_decoder_pkg::bank_kernel;
      end else if (access_en) begin
         sel_q <= sel;
      end
   end

   assign rd_data = (sel_q == mem_decoder_pkg::bank_arg) ? arg_rdata : kernel_rdata;

endmodule

`default_nettype wire

// ==== source/access_fsm.sv ====
`default_nettype none

module access_fsm (
   input  logic                                clk,
   input  logic                                reset,
   input  logic                                req_valid,
   output logic                                req_ready,
   input  mem_decoder_pkg::mem_req_t           req,
   output logic                                rsp_valid,
   input  logic                                rsp_ready,
   output mem_decoder_pkg::mem_rsp_t           rsp,
   output mem_decoder_pkg::mem_req_t           held_req,
   output logic                                access_en,
   input  logic [mem_decoder_pkg::data_w-1:0]  rd_data
);

   // access spans two cycles, strobe then read word
   typedef enum logic [1:0] {
      st_idle,
      st_access,
      st_respond
   } state_t;

   state_t state;
   state_t state_next;
   logic   accept;
   logic   rd_capture;

   //////////////////////////////
   // handshake flags
   //////////////////////////////

   // ready only while nothing is in flight
   assign req_ready = (state == st_idle);
   assign rsp_valid = (state == st_respond);
   assign accept = req_valid && req_ready;
   // second access cycle, bank word sits on rd_data
   assign rd_capture = (state == st_access) && !access_en;

   //////////////////////////////
   // next state
   //////////////////////////////

   always_comb begin
      state_next = state;
      case (state)
         st_idle: begin
            if (accept) begin
               state_next = st_access;
            end
         end
         st_access: begin
            if (rd_capture) begin
               state_next = st_respond;
            end
         end
         st_respond: begin
            // hold until the master takes the word
            if (rsp_ready) begin
               state_next = st_idle;
            end
         end
         default: begin
            state_next = st_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_idle;
         access_en <= 1'b0;
      end else begin
         state     <= state_next;
         // one cycle strobe right after the accept edge
         access_en <= accept;
      end
   end

   // payload, loaded on accept and on response entry
   always_ff @(posedge clk) begin
      if (accept) begin
         held_req <= req;
      end
      if (rd_capture) begin
         rsp.rdata <= rd_data;
      end
   end

endmodule

`default_nettype wire

// ==== source/mem_decoder_top.sv ====
`default_nettype none

module mem_decoder_top #(
   parameter int kernel_words = 256,
   parameter int arg_words    = 64
) (
   input  logic                        clk,
   input  logic                        reset,
   input  logic                        req_valid,
   output logic                        req_ready,
   input  mem_decoder_pkg::mem_req_t   req,
   output logic                        rsp_valid,
   input  logic                        rsp_ready,
   output mem_decoder_pkg::mem_rsp_t   rsp
);

   // fsm to decoder
   mem_decoder_pkg::mem_req_t              held_req;
   logic                                   access_en;
   logic [mem_decoder_pkg::data_w-1:0]     rd_data;

   // decoder to banks
   logic                                   kernel_en;
   logic                                   arg_en;
   logic                                   bank_we;
   logic [$clog2(kernel_words)-1:0]        kernel_offset;
   logic [$clog2(arg_words)-1:0]           arg_offset;
   logic [mem_decoder_pkg::data_w-1:0]     bank_wdata;
   logic [mem_decoder_pkg::strb_w-1:0]     bank_strb;
   logic [mem_decoder_pkg::data_w-1:0]     kernel_rdata;
   logic [mem_decoder_pkg::data_w-1:0]     arg_rdata;

   //////////////////////////////
   // handshake and decode
   //////////////////////////////

   access_fsm u_access_fsm (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp),
      .held_req  (held_req),
      .access_en (access_en),
      .rd_data   (rd_data)
   );

   bank_select #(
      .kernel_words (kernel_words),
      .arg_words    (arg_words)
   ) u_bank_select (
      .clk           (clk),
      .reset         (reset),
      .access_en     (access_en),
      .held_req      (held_req),
      .rd_data       (rd_data),
      .kernel_en     (kernel_en),
      .arg_en        (arg_en),
      .bank_we       (bank_we),
      .kernel_offset (kernel_offset),
      .arg_offset    (arg_offset),
      .bank_wdata    (bank_wdata),
      .bank_strb     (bank_strb),
      .kernel_rdata  (kernel_rdata),
      .arg_rdata     (arg_rdata)
   );

   //////////////////////////////
   // banks
   //////////////////////////////

   // kernel image, also the default region
   ram_bank #(
      .bank_words (kernel_words)
   ) kernel_ram (
      .clk    (clk),
      .en     (kernel_en),
      .we     (bank_we),
      .offset (kernel_offset),
      .wdata  (bank_wdata),
      .strb   (bank_strb),
      .rdata  (kernel_rdata)
   );

   // kernel arguments
   ram_bank #(
      .bank_words (arg_words)
   ) arg_ram (
      .clk    (clk),
      .en     (arg_en),
      .we     (bank_we),
      .offset (arg_offset),
      .wdata  (bank_wdata),
      .strb   (bank_strb),
      .rdata  (arg_rdata)
   );

endmodule

`default_nettype wire

// ==== include/mem_decoder_vectors.svh ====
`ifndef MEM_DECODER_VECTORS_SVH
`define MEM_DECODER_VECTORS_SVH

// columns: write, address, write data, strobes, check kind, expected word
// the expected word is the old content, also for writes
// chk_none on first touch of a word, its content is unknown
localparam int n_vectors = 30;

localparam vector_t vectors [n_vectors] = '{
   // kernel bank, write then read back, read-first on rewrite
   '{1'b1, 32'h8000_0010, 32'h1111_2222, 4'hf, chk_none,  32'h0000_0000},
   '{1'b0, 32'h8000_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'h1111_2222},
   '{1'b1, 32'h8000_0010, 32'ha5a5_5a5a, 4'hf, chk_fixed, 32'h1111_2222},
   '{1'b0, 32'h8000_0010, 32'hffff_ffff, 4'hf, chk_model, 32'h0000_0000},
   // argument bank at the same word offset
   '{1'b1, 32'h0001_0010, 32'h3333_4444, 4'hf, chk_none,  32'h0000_0000},
   '{1'b0, 32'h0001_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'h3333_4444},
   '{1'b0, 32'h8000_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'ha5a5_5a5a},
   '{1'b1, 32'h8000_0010, 32'hdead_beef, 4'hf, chk_model, 32'h0000_0000},
   '{1'b0, 32'h0001_0010, 32'hffff_ffff, 4'hf, chk_model, 32'h0000_0000},
   '{1'b0, 32'h8000_0010, 32'hffff_ffff, 4'hf, chk_model, 32'h0000_0000},
   // default region lands in the kernel bank
   '{1'b0, 32'h0000_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'hdead_beef},
   '{1'b1, 32'h0000_0010, 32'h0bad_f00d, 4'hf, chk_fixed, 32'hdead_beef},
   '{1'b0, 32'h8000_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'h0bad_f00d},
   // kernel offset wraps every 256 words
   '{1'b0, 32'h8000_0410, 32'hffff_ffff, 4'hf, chk_fixed, 32'h0bad_f00d},
   '{1'b0, 32'h7ffe_2010, 32'hffff_ffff, 4'hf, chk_model, 32'h0000_0000},
   // arg offset wraps every 64 words
   '{1'b1, 32'h0001_0110, 32'h5555_6666, 4'hf, chk_fixed, 32'h3333_4444},
   '{1'b0, 32'h0001_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'h5555_6666},
   // bit 31 wins over bit 16
   '{1'b0, 32'h8001_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'h0bad_f00d},
   '{1'b0, 32'h7fff_0f10, 32'hffff_ffff, 4'hf, chk_model, 32'h0000_0000},
   // partial byte strobes
   '{1'b1, 32'h8000_0010, 32'h1122_3344, 4'h5, chk_fixed, 32'h0bad_f00d},
   '{1'b0, 32'h8000_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'h0b22_f044},
   '{1'b1, 32'h0001_0010, 32'haabb_ccdd, 4'h8, chk_fixed, 32'h5555_6666},
   '{1'b0, 32'h0001_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'haa55_6666},
   '{1'b1, 32'h8000_0010, 32'hffff_ffff, 4'h0, chk_model, 32'h0000_0000},
   '{1'b0, 32'h8000_0010, 32'hffff_ffff, 4'hf, chk_fixed, 32'h0b22_f044},
   // last word of each bank
   '{1'b1, 32'h8000_03fc, 32'h7777_8888, 4'hf, chk_none,  32'h0000_0000},
   '{1'b0, 32'hffff_fffc, 32'hffff_ffff, 4'hf, chk_fixed, 32'h7777_8888},
   '{1'b1, 32'h0001_00fc, 32'h9999_0000, 4'hf, chk_none,  32'h0000_0000},
   '{1'b0, 32'h0001_00fc, 32'hffff_ffff, 4'hf, chk_fixed, 32'h9999_0000},
   '{1'b0, 32'h0000_03fc, 32'hffff_ffff, 4'hf, chk_model, 32'h0000_0000}
};

`endif

// ==== dv/mem_decoder_tb.sv ====
`default_nettype none

module mem_decoder_tb;

   localparam int kernel_words = 256;
   localparam int arg_words    = 64;
   localparam int k_idx_w      = $clog2(kernel_words);
   localparam int a_idx_w      = $clog2(arg_words);

   // how a table entry checks its response word
   localparam logic [1:0] chk_none  = 2'd0;
   localparam logic [1:0] chk_fixed = 2'd1;
   localparam logic [1:0] chk_model = 2'd2;

   typedef struct packed {
      logic                                write;
      logic [mem_decoder_pkg::addr_w-1:0]  addr;
      logic [mem_decoder_pkg::data_w-1:0]  data;
      logic [mem_decoder_pkg::strb_w-1:0]  strb;
      logic [1:0]                          kind;
      logic [mem_decoder_pkg::data_w-1:0]  exp_word;
   } vector_t;

`include "mem_decoder_vectors.svh"

   // longest stall on rsp_ready in cycles
   localparam int max_stall = 3;
   // drive, accept, two access cycles, response, idle check
   localparam int cycles_per_vector = 5;
   localparam int timeout_cycles = n_vectors * (cycles_per_vector + max_stall) + 20;

   logic                        clk = 1'b0;
   logic                        reset;
   logic                        req_valid;
   logic                        req_ready;
   mem_decoder_pkg::mem_req_t   req;
   logic                        rsp_valid;
   logic                        rsp_ready;
   mem_decoder_pkg::mem_rsp_t   rsp;

   logic [31:0] rng_state;
   int          stall;
   int          cycle_count = 0;

   // bank images under the region decode
   logic [mem_decoder_pkg::data_w-1:0] kernel_model [kernel_words];
   logic [mem_decoder_pkg::data_w-1:0] arg_model [arg_words];

   mem_decoder_top #(
      .kernel_words (kernel_words),
      .arg_words    (arg_words)
   ) dut (
      .clk       (clk),
      .reset     (reset),
      .req_valid (req_valid),
      .req_ready (req_ready),
      .req       (req),
      .rsp_valid (rsp_valid),
      .rsp_ready (rsp_ready),
      .rsp       (rsp)
   );

   always #50 clk = ~clk;

   //////////////////////////////
   // failure handling
   //////////////////////////////

   task automatic stop_failed();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("MISMATCH %s: got 0x%h, expected 0x%h", name, actual, expected);
         stop_failed();
      end
   endtask

   // run limit from table length and worst stall
   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("timeout: the DUT stopped making progress after %0d cycles", cycle_count);
         stop_failed();
      end
   end

   //////////////////////////////
   // stall source and model
   //////////////////////////////

   function automatic logic [31:0] next_random(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // old word with enabled byte lanes replaced
   function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                               input logic [31:0] new_word,
                                               input logic [3:0] strb);
      logic [31:0] mask;
      mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
      return (old_word & ~mask) | (new_word & mask);
   endfunction

   // returns the word before the access and applies a write
   task automatic model_access(input vector_t v, output logic [31:0] old_word);
      logic [31:0]        word_index;
      logic [k_idx_w-1:0] k_idx;
      logic [a_idx_w-1:0] a_idx;
      word_index = v.addr >> mem_decoder_pkg::byte_offset_w;
      k_idx = k_idx_w'(word_index % kernel_words);
      a_idx = a_idx_w'(word_index % arg_words);
      // arg window needs bit 16 with bit 31 clear
      if (!v.addr[mem_decoder_pkg::kernel_region_bit] &&
          v.addr[mem_decoder_pkg::arg_region_bit]) begin
         old_word = arg_model[a_idx];
         if (v.write) begin
            arg_model[a_idx] = merge_bytes(old_word, v.data, v.strb);
         end
      end else begin
         old_word = kernel_model[k_idx];
         if (v.write) begin
            kernel_model[k_idx] = merge_bytes(old_word, v.data, v.strb);
         end
      end
   endtask

   //////////////////////////////
   // one transaction
   //////////////////////////////

   // called on a rising edge and returns on one
   task automatic run_vector(input vector_t v, input int stall_cycles);
      mem_decoder_pkg::mem_rsp_t first_rsp;
      logic [31:0]               model_old;
      logic [31:0]               expected;
      int                        stall_left;
      model_access(v, model_old);
      case (v.kind)
         chk_fixed: expected = v.exp_word;
         chk_model: expected = model_old;
         default:   expected = '0;
      endcase
      req_valid <= 1'b1;
      req <= '{write: v.write, addr: v.addr, wdata: v.data, strb: v.strb};
      rsp_ready <= (stall_cycles == 0);
      // accept edge
      @(posedge clk);
      while (!req_ready) begin
         @(posedge clk);
      end
      req_valid <= 1'b0;
      // nothing visible while the access is in flight
      repeat (2) begin
         @(posedge clk);
         check_value("req_ready", 32'(req_ready), 32'h0);
         check_value("rsp_valid", 32'(rsp_valid), 32'h0);
      end
      @(posedge clk);
      check_value("rsp_valid", 32'(rsp_valid), 32'h1);
      check_value("req_ready", 32'(req_ready), 32'h0);
      if (v.kind != chk_none) begin
         check_value("rsp.rdata", rsp.rdata, expected);
      end
      first_rsp = rsp;
      stall_left = stall_cycles;
      // response must hold under back-pressure
      while (!rsp_ready) begin
         stall_left--;
         if (stall_left == 0) begin
            rsp_ready <= 1'b1;
         end
         @(posedge clk);
         check_value("rsp_valid", 32'(rsp_valid), 32'h1);
         check_value("rsp.rdata", rsp.rdata, first_rsp.rdata);
         check_value("req_ready", 32'(req_ready), 32'h0);
      end
      // taken on this edge
      rsp_ready <= 1'b0;
      @(posedge clk);
      check_value("req_ready", 32'(req_ready), 32'h1);
      check_value("rsp_valid", 32'(rsp_valid), 32'h0);
   endtask

   initial begin
      reset = 1'b1;
      req_valid = 1'b0;
      rsp_ready = 1'b0;
      req = '0;
      rng_state = 32'h947e;
      repeat (2) @(posedge clk);
      reset <= 1'b0;
      @(posedge clk);
      // idle state straight out of reset
      check_value("req_ready", 32'(req_ready), 32'h1);
      check_value("rsp_valid", 32'(rsp_valid), 32'h0);
      for (int i = 0; i < n_vectors; i++) begin
         rng_state = next_random(rng_state);
         stall = int'(rng_state % (max_stall + 1));
         run_vector(vectors[i], stall);
      end
      $display("Simulation passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+include
source/mem_decoder_pkg.sv
source/ram_bank.sv
source/bank_select.sv
source/access_fsm.sv
source/mem_decoder_top.sv
dv/mem_decoder_tb.sv

// ==== Makefile ====
# Verilator build and run of the memory decoder testbench

TOP = mem_decoder_tb

.PHONY: sim clean

# pass only when the log holds the pass message
sim:
	verilator --binary --timing --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log
